/* hw/arcade_cfg_pkg.sv */
//==============================
// platform configuration defs
//==============================

package arcade_cfg_pkg;

	// scanline dimming applied to odd lines
	typedef enum logic [1:0] {
		sl_off = 2'd0,
		sl_25  = 2'd1, // lose a quarter
		sl_50  = 2'd2, // lose half
		sl_75  = 2'd3  // keep a quarter
	} scanline_mode_e;

	// host status word fields
	localparam int st_reset      = 0;
	localparam int st_rotate     = 2;
	localparam int st_scan_lo    = 3; // two bits, scan_lo and scan_lo+1
	localparam int st_trig_reset = 6;

	// top-level parameter defaults
	localparam int default_dac_width   = 10;
	localparam int default_color_depth = 4;
	localparam int default_slow_div    = 14; // 25 MHz / 14 -> ~1.79 MHz

endpackage

/* hw/arcade_input_pkg.sv */
//==============================
// keyboard and player inputs
//==============================

package arcade_input_pkg;

	// ps/2 set-2 make codes in use
	typedef enum logic [7:0] {
		kc_f1     = 8'h05,
		kc_f2     = 8'h06,
		kc_alt    = 8'h11,
		kc_lshift = 8'h12,
		kc_ctrl   = 8'h14,
		kc_space  = 8'h29,
		kc_left   = 8'h6B,
		kc_down   = 8'h72,
		kc_right  = 8'h74,
		kc_up     = 8'h75,
		kc_esc    = 8'h76
	} key_code_e;

	// bit positions in the core's seven-bit player word
	localparam int pw_right = 0;
	localparam int pw_left  = 1;
	localparam int pw_fire1 = 2;
	localparam int pw_fire2 = 3;
	localparam int pw_fire3 = 4;
	localparam int pw_fire4 = 5;
	localparam int pw_start = 6;

	localparam int pw_width = 7;

endpackage

/* hw/clock_enables.sv */
//==============================
// core clock enables
//==============================
`timescale 1ns/10ps

module clock_enables #(
	parameter int slow_div = 14 // clk_sys cycles per ce_1p79
) (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_1p79
);

	localparam int slow_w = (slow_div > 1) ? $clog2(slow_div) : 1;

	logic [1:0]        phase;    // 12/6 MHz phase counter
	logic [slow_w-1:0] slow_cnt; // down-counter for the slow strobe

	// ==============================
	// fast strobes
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= '0;
			ce_12 <= 1'b0;
			ce_6p <= 1'b0;
			ce_6n <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce_12 <= phase[0];              // every other cycle
			ce_6p <= phase[0] & ~phase[1];  // phase 1
			ce_6n <= phase[0] & phase[1];   // phase 3, two cycles later
		end
	end

	// ==============================
	// slow strobe
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slow_cnt <= '0;
			ce_1p79  <= 1'b0;
		end else if (slow_cnt == '0) begin
			slow_cnt <= slow_w'(slow_div - 1); // reload
			ce_1p79  <= 1'b1;
		end else begin
			slow_cnt <= slow_cnt - 1'b1;
			ce_1p79  <= 1'b0;
		end
	end

endmodule

/* hw/key_decoder.sv */
//==============================
// keyboard button latch
//==============================
`timescale 1ns/10ps

module key_decoder (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       key_strobe,  // one cycle per make or break
	input  logic       key_pressed, // 1 make, 0 break
	input  logic [7:0] key_code,
	output logic       btn_up,
	output logic       btn_down,
	output logic       btn_left,
	output logic       btn_right,
	output logic       btn_coin,
	output logic       btn_start1,
	output logic       btn_start2,
	output logic       btn_fire1,
	output logic       btn_fire2,
	output logic       btn_fire3
);

	import arcade_input_pkg::*;

	// each button holds its level between make and break
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
			btn_fire1  <= 1'b0;
			btn_fire2  <= 1'b0;
			btn_fire3  <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				kc_up:     btn_up     <= key_pressed;
				kc_down:   btn_down   <= key_pressed;
				kc_left:   btn_left   <= key_pressed;
				kc_right:  btn_right  <= key_pressed;
				kc_esc:    btn_coin   <= key_pressed; // coin
				kc_f1:     btn_start1 <= key_pressed; // one player
				kc_f2:     btn_start2 <= key_pressed; // two players
				kc_space:  btn_fire1  <= key_pressed;
				kc_alt:    btn_fire2  <= key_pressed;
				kc_lshift: btn_fire3  <= key_pressed; // shift and ctrl share fire3
				kc_ctrl:   btn_fire3  <= key_pressed;
				default:   ; // other codes ignored
			endcase
		end
	end

endmodule

/* hw/control_mapper.sv */
//==============================
// player input mapping
//==============================
`timescale 1ns/10ps

module control_mapper (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       rotate,     // 0 rotated cabinet, 1 direct
	input  logic       btn_up,
	input  logic       btn_down,
	input  logic       btn_left,
	input  logic       btn_right,
	input  logic       btn_coin,
	input  logic       btn_start1,
	input  logic       btn_start2,
	input  logic       btn_fire1,
	input  logic       btn_fire2,
	input  logic       btn_fire3,
	input  logic [7:0] joy0,       // 0 r, 1 l, 2 d, 3 u, 4..7 fire
	input  logic [7:0] joy1,
	output logic [6:0] ip_1p,      // active low
	output logic [6:0] ip_2p,      // active low
	output logic       ip_coin1    // active low
);

	import arcade_input_pkg::*;

	logic [pw_width-1:0] p1_word; // active-high, before inversion
	logic [pw_width-1:0] p2_word;

	always_comb begin
		// player 1, keys or'd with joystick 0
		p1_word[pw_left]  = rotate ? (btn_left | joy0[1]) : (btn_down | joy0[2]);
		p1_word[pw_right] = rotate ? (btn_right | joy0[0]) : (btn_up | joy0[3]);
		p1_word[pw_fire1] = btn_fire1 | joy0[4];
		p1_word[pw_fire2] = btn_fire2 | joy0[5];
		p1_word[pw_fire3] = btn_fire3 | joy0[6];
		p1_word[pw_fire4] = joy0[7];   // no key for fire4
		p1_word[pw_start] = btn_start1;
		// player 2, joystick 1 only
		p2_word[pw_left]  = rotate ? joy1[1] : joy1[2];
		p2_word[pw_right] = rotate ? joy1[0] : joy1[3];
		p2_word[pw_fire1] = joy1[4];
		p2_word[pw_fire2] = joy1[5];
		p2_word[pw_fire3] = joy1[6];
		p2_word[pw_fire4] = joy1[7];
		p2_word[pw_start] = btn_start2;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ip_1p    <= '1; // nothing pressed
			ip_2p    <= '1;
			ip_coin1 <= 1'b1;
		end else begin
			ip_1p    <= ~p1_word;
			ip_2p    <= ~p2_word;
			ip_coin1 <= ~btn_coin;
		end
	end

endmodule

/* hw/config_regs.sv */
//==============================
// host status and core reset
//==============================
`timescale 1ns/10ps

module config_regs (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          status_we,
	input  logic [31:0]                   status_data,
	input  logic                          host_reset_btn,
	output logic                          rotate,
	output arcade_cfg_pkg::scanline_mode_e scan_mode,
	output logic                          core_reset
);

	import arcade_cfg_pkg::*;

	logic [31:0] status; // copy of the host status word

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status     <= '0;
			core_reset <= 1'b1; // held through reset, one cycle past it
		end else begin
			if (status_we)
				status <= status_data;
			// reset menu bit, trigger bit or board button
			core_reset <= status[st_reset] | status[st_trig_reset] | host_reset_btn;
		end
	end

	// field decode
	assign rotate    = status[st_rotate];
	assign scan_mode = scanline_mode_e'(status[st_scan_lo +: 2]);

endmodule

/* hw/video_blanker.sv */
//==============================
// blanking and scanlines
//==============================
`timescale 1ns/10ps

module video_blanker #(
	parameter int color_depth = 4
) (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  arcade_cfg_pkg::scanline_mode_e scan_mode,
	input  logic [color_depth-1:0]         core_r,
	input  logic [color_depth-1:0]         core_g,
	input  logic [color_depth-1:0]         core_b,
	input  logic                           core_hs,     // active high from core
	input  logic                           core_vs,
	input  logic                           core_hblank,
	input  logic                           core_vblank,
	output logic [color_depth-1:0]         vid_r,
	output logic [color_depth-1:0]         vid_g,
	output logic [color_depth-1:0]         vid_b,
	output logic                           vid_hs,      // active low
	output logic                           vid_vs
);

	import arcade_cfg_pkg::*;

	logic hs_prev;  // for the hsync rising edge
	logic line_odd; // current line parity
	logic blank;

	// dimmed value for odd lines
	function automatic logic [color_depth-1:0] dim(input logic [color_depth-1:0] v,
		input scanline_mode_e mode);
		case (mode)
			sl_25:   dim = v - (v >> 2);
			sl_50:   dim = v >> 1;
			sl_75:   dim = v >> 2;
			default: dim = v;
		endcase
	endfunction

	assign blank = core_hblank | core_vblank;

	// ==============================
	// line parity
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev  <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_prev <= core_hs;
			if (core_vs)
				line_odd <= 1'b0;       // new frame starts even
			else if (core_hs & ~hs_prev)
				line_odd <= ~line_odd;
		end
	end

	// colour and sync, same single stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vid_r  <= '0;
			vid_g  <= '0;
			vid_b  <= '0;
			vid_hs <= 1'b0;
			vid_vs <= 1'b0;
		end else begin
			vid_r  <= blank ? '0 : (line_odd ? dim(core_r, scan_mode) : core_r);
			vid_g  <= blank ? '0 : (line_odd ? dim(core_g, scan_mode) : core_g);
			vid_b  <= blank ? '0 : (line_odd ? dim(core_b, scan_mode) : core_b);
			vid_hs <= ~core_hs;
			vid_vs <= ~core_vs;
		end
	end

endmodule

/* hw/sigma_delta_dac.sv */
//==============================
// one-bit audio DAC
//==============================
`timescale 1ns/10ps

module sigma_delta_dac #(
	parameter int dac_width = 10
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [dac_width-1:0] dac_in,  // unsigned sample
	output logic                 dac_out  // pulse density output
);

	logic [dac_width-1:0] acc; // error accumulator
	logic [dac_width:0]   sum; // acc plus input, carry on top

	assign sum = {1'b0, acc} + {1'b0, dac_in};

	// first order, the carry is the output bit
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[dac_width-1:0];
			dac_out <= sum[dac_width];
		end
	end

endmodule

/* hw/arcade_io_top.sv */
//==============================
// arcade platform io top
//==============================
`timescale 1ns/10ps

module arcade_io_top #(
	parameter int dac_width   = arcade_cfg_pkg::default_dac_width,
	parameter int color_depth = arcade_cfg_pkg::default_color_depth,
	parameter int slow_div    = arcade_cfg_pkg::default_slow_div
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	// keyboard
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  logic [7:0]             key_code,
	// joysticks
	input  logic [7:0]             joy0,
	input  logic [7:0]             joy1,
	// host
	input  logic                   status_we,
	input  logic [31:0]            status_data,
	input  logic                   host_reset_btn,
	// core video and audio
	input  logic [color_depth-1:0] core_r,
	input  logic [color_depth-1:0] core_g,
	input  logic [color_depth-1:0] core_b,
	input  logic                   core_hs,
	input  logic                   core_vs,
	input  logic                   core_hblank,
	input  logic                   core_vblank,
	input  logic [dac_width-1:0]   core_audio,
	// to core
	output logic                   ce_12,
	output logic                   ce_6p,
	output logic                   ce_6n,
	output logic                   ce_1p79,
	output logic [6:0]             ip_1p,
	output logic [6:0]             ip_2p,
	output logic                   ip_coin1,
	output logic                   core_reset,
	// to board
	output logic [color_depth-1:0] vid_r,
	output logic [color_depth-1:0] vid_g,
	output logic [color_depth-1:0] vid_b,
	output logic                   vid_hs,
	output logic                   vid_vs,
	output logic                   audio_l,
	output logic                   audio_r
);

	import arcade_cfg_pkg::*;

	logic btn_up, btn_down, btn_left, btn_right, btn_coin;
	logic btn_start1, btn_start2, btn_fire1, btn_fire2, btn_fire3;
	logic           rotate;
	scanline_mode_e scan_mode;

	clock_enables #(.slow_div(slow_div)) u_clock_enables (
		.clk_sys(clk_sys), .reset(reset),
		.ce_12(ce_12), .ce_6p(ce_6p), .ce_6n(ce_6n), .ce_1p79(ce_1p79)
	);

	key_decoder u_key_decoder (
		.clk_sys(clk_sys), .reset(reset),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
		.btn_coin(btn_coin), .btn_start1(btn_start1), .btn_start2(btn_start2),
		.btn_fire1(btn_fire1), .btn_fire2(btn_fire2), .btn_fire3(btn_fire3)
	);

	control_mapper u_control_mapper (
		.clk_sys(clk_sys), .reset(reset), .rotate(rotate),
		.btn_up(btn_up), .btn_down(btn_down), .btn_left(btn_left), .btn_right(btn_right),
		.btn_coin(btn_coin), .btn_start1(btn_start1), .btn_start2(btn_start2),
		.btn_fire1(btn_fire1), .btn_fire2(btn_fire2), .btn_fire3(btn_fire3),
		.joy0(joy0), .joy1(joy1),
		.ip_1p(ip_1p), .ip_2p(ip_2p), .ip_coin1(ip_coin1)
	);

	config_regs u_config_regs (
		.clk_sys(clk_sys), .reset(reset),
		.status_we(status_we), .status_data(status_data), .host_reset_btn(host_reset_btn),
		.rotate(rotate), .scan_mode(scan_mode), .core_reset(core_reset)
	);

	video_blanker #(.color_depth(color_depth)) u_video_blanker (
		.clk_sys(clk_sys), .reset(reset), .scan_mode(scan_mode),
		.core_r(core_r), .core_g(core_g), .core_b(core_b),
		.core_hs(core_hs), .core_vs(core_vs),
		.core_hblank(core_hblank), .core_vblank(core_vblank),
		.vid_r(vid_r), .vid_g(vid_g), .vid_b(vid_b), .vid_hs(vid_hs), .vid_vs(vid_vs)
	);

	sigma_delta_dac #(.dac_width(dac_width)) u_sigma_delta_dac (
		.clk_sys(clk_sys), .reset(reset),
		.dac_in(core_audio), .dac_out(audio_l)
	);

	assign audio_r = audio_l; // mono core, both channels

endmodule

/* tb/tb_clock_gen.sv */
//==============================
// testbench clock and reset
//==============================
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	// reset held for three rising edges
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

/* tb/arcade_io_properties.sv */
//==============================
// bound strobe and blank checks
//==============================
`timescale 1ns/10ps

module arcade_io_properties #(
	parameter int color_depth = 4
) (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   ce_12,
	input logic                   ce_6p,
	input logic                   ce_6n,
	input logic                   ce_1p79,
	input logic                   core_hblank,
	input logic                   core_vblank,
	input logic [color_depth-1:0] vid_r,
	input logic [color_depth-1:0] vid_g,
	input logic [color_depth-1:0] vid_b
);

	// two 6 MHz phases never overlap
	a_6_phases: assert property (@(posedge clk_sys) disable iff (reset) !(ce_6p && ce_6n))
		else $error("ce_6p and ce_6n high together");

	a_6p_in_12: assert property (@(posedge clk_sys) disable iff (reset) ce_6p |-> ce_12)
		else $error("ce_6p without ce_12");

	// first cycle out of reset, all quiet
	a_quiet_after_reset: assert property (@(posedge clk_sys)
		($past(reset) && !reset) |-> !(ce_12 || ce_6p || ce_6n || ce_1p79))
		else $error("strobe high in first cycle after reset");

	a_blank_black: assert property (@(posedge clk_sys) disable iff (reset)
		(core_hblank || core_vblank) |=> (vid_r == '0 && vid_g == '0 && vid_b == '0))
		else $error("colour not zero after blanking");

endmodule

bind arcade_io_top arcade_io_properties #(.color_depth(color_depth)) u_properties (
	.clk_sys(clk_sys), .reset(reset),
	.ce_12(ce_12), .ce_6p(ce_6p), .ce_6n(ce_6n), .ce_1p79(ce_1p79),
	.core_hblank(core_hblank), .core_vblank(core_vblank),
	.vid_r(vid_r), .vid_g(vid_g), .vid_b(vid_b)
);

/* tb/arcade_io_tb.sv */
//==============================
// arcade io testbench
//==============================
`timescale 1ns/10ps

module arcade_io_tb;

	import arcade_cfg_pkg::*;
	import arcade_input_pkg::*;

	localparam int dac_w    = 6;
	localparam int col_w    = 4;
	localparam int n_strobe = 280;
	localparam int n_keys   = 200;
	localparam int n_status = 200;
	localparam int n_video  = 150;
	localparam int n_audio  = 6;
	// summed test lengths plus margin
	localparam int watchdog_cycles = 10 + n_strobe + 2 * (n_keys + 8) + n_status + 8
		+ 4 * (n_video + 12) + n_audio * 130 + 300;

	logic clk_sys, reset;
	logic key_strobe, key_pressed;
	logic [7:0] key_code, joy0, joy1;
	logic status_we, host_reset_btn;
	logic [31:0] status_data;
	logic [col_w-1:0] core_r, core_g, core_b, vid_r, vid_g, vid_b;
	logic core_hs, core_vs, core_hblank, core_vblank, vid_hs, vid_vs;
	logic [dac_w-1:0] core_audio;
	logic ce_12, ce_6p, ce_6n, ce_1p79, ip_coin1, core_reset, audio_l, audio_r;
	logic [6:0] ip_1p, ip_2p;

	logic [31:0] rng = 32'h3fb5; // xorshift state
	int checks = 0;
	int errors = 0;
	logic [7:0] known_codes [11];

	// model state
	logic [31:0] st_model = '0;
	logic m_up, m_down, m_left, m_right, m_coin;
	logic m_start1, m_start2, m_fire1, m_fire2, m_fire3;
	logic m_odd, m_hs_prev; // line parity model

	tb_clock_gen u_clock_gen (.clk_sys(clk_sys), .reset(reset));

	arcade_io_top #(.dac_width(dac_w), .color_depth(col_w), .slow_div(14)) dut (
		.clk_sys(clk_sys), .reset(reset),
		.key_strobe(key_strobe), .key_pressed(key_pressed), .key_code(key_code),
		.joy0(joy0), .joy1(joy1),
		.status_we(status_we), .status_data(status_data), .host_reset_btn(host_reset_btn),
		.core_r(core_r), .core_g(core_g), .core_b(core_b), .core_hs(core_hs),
		.core_vs(core_vs), .core_hblank(core_hblank), .core_vblank(core_vblank),
		.core_audio(core_audio),
		.ce_12(ce_12), .ce_6p(ce_6p), .ce_6n(ce_6n), .ce_1p79(ce_1p79),
		.ip_1p(ip_1p), .ip_2p(ip_2p), .ip_coin1(ip_coin1), .core_reset(core_reset),
		.vid_r(vid_r), .vid_g(vid_g), .vid_b(vid_b), .vid_hs(vid_hs), .vid_vs(vid_vs),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// odd-line dimming per scanline mode
	function automatic int dim_expect(input int v, input int mode);
		case (mode)
			1:       return v - v / 4;
			2:       return v / 2;
			3:       return v / 4;
			default: return v;
		endcase
	endfunction

	task automatic write_status(input logic [31:0] v);
		@(posedge clk_sys);
		status_we   <= 1'b1;
		status_data <= v;
		@(posedge clk_sys);
		status_we <= 1'b0;
		repeat (2) @(posedge clk_sys); // let fields settle
		st_model = v;
	endtask

	// model of the make/break latch
	task automatic update_buttons(input logic [7:0] code, input logic p);
		case (code)
			8'h75: m_up = p;
			8'h72: m_down = p;
			8'h6B: m_left = p;
			8'h74: m_right = p;
			8'h76: m_coin = p;   // esc
			8'h05: m_start1 = p; // f1
			8'h06: m_start2 = p; // f2
			8'h29: m_fire1 = p;  // space
			8'h11: m_fire2 = p;  // alt
			8'h12, 8'h14: m_fire3 = p; // shift or ctrl
			default: ;
		endcase
	endtask

	// ==============================
	// tests
	// ==============================
	task automatic count_strobes();
		int cnt [4];
		int last [4];
		int gap [4];
		logic [3:0] s;
		gap = '{2, 4, 4, 14};
		for (int j = 0; j < 4; j++) begin
			cnt[j] = 0;
			last[j] = -1;
		end
		for (int i = 0; i < n_strobe; i++) begin
			@(negedge clk_sys);
			s = {ce_1p79, ce_6n, ce_6p, ce_12};
			for (int j = 0; j < 4; j++) begin
				if (s[j]) begin
					if (last[j] >= 0)
						check_val(i - last[j], gap[j], "strobe gap");
					last[j] = i;
					cnt[j]++;
				end
			end
			if (ce_6n && last[1] >= 0)
				check_val(i - last[1], 2, "6p to 6n spacing");
		end
		check_val(cnt[0], 140, "ce_12 count");
		check_val(cnt[1], 70, "ce_6p count");
		check_val(cnt[2], 70, "ce_6n count");
		check_val(cnt[3], 20, "ce_1p79 count");
	endtask

	task automatic press_keys(input logic rot);
		logic o_strobe, o_pressed;
		logic [7:0] o_code, o_j0, o_j1;
		logic [31:0] r;
		logic [6:0] w1, w2;
		write_status(rot ? (32'd1 << st_rotate) : 32'd0);
		for (int i = 0; i < n_keys; i++) begin
			o_strobe  = key_strobe;
			o_pressed = key_pressed;
			o_code    = key_code;
			o_j0      = joy0;
			o_j1      = joy1;
			@(posedge clk_sys);
			r = next_random();
			key_strobe  <= (i != n_keys - 1) && (r[1:0] == 2'd0); // last one quiet
			key_pressed <= r[2];
			key_code    <= (r[7:4] >= 4'd11) ? r[15:8] : known_codes[r[7:4]];
			if (r[18:16] == 3'd0)
				joy0 <= r[31:24];
			if (r[21:19] == 3'd0)
				joy1 <= r[23:16];
			@(negedge clk_sys);
			w1[pw_left]  = rot ? (m_left | o_j0[1]) : (m_down | o_j0[2]);
			w1[pw_right] = rot ? (m_right | o_j0[0]) : (m_up | o_j0[3]);
			w1[pw_fire1] = m_fire1 | o_j0[4];
			w1[pw_fire2] = m_fire2 | o_j0[5];
			w1[pw_fire3] = m_fire3 | o_j0[6];
			w1[pw_fire4] = o_j0[7];
			w1[pw_start] = m_start1;
			w2[pw_left]  = rot ? o_j1[1] : o_j1[2];
			w2[pw_right] = rot ? o_j1[0] : o_j1[3];
			w2[pw_fire1] = o_j1[4];
			w2[pw_fire2] = o_j1[5];
			w2[pw_fire3] = o_j1[6];
			w2[pw_fire4] = o_j1[7];
			w2[pw_start] = m_start2;
			check_val(ip_1p, 7'(~w1), "ip_1p");
			check_val(ip_2p, 7'(~w2), "ip_2p");
			check_val(ip_coin1, !m_coin, "ip_coin1");
			if (o_strobe)
				update_buttons(o_code, o_pressed); // buttons move after the mapper sample
		end
	endtask

	task automatic poke_status();
		logic o_we, o_btn;
		logic [31:0] o_data, r;
		for (int i = 0; i < n_status; i++) begin
			o_we   = status_we;
			o_btn  = host_reset_btn;
			o_data = status_data;
			@(posedge clk_sys);
			r = next_random();
			status_we      <= (i != n_status - 1) && (r[1:0] == 2'd0);
			status_data    <= next_random();
			host_reset_btn <= (i != n_status - 1) && (r[4:2] == 3'd0);
			@(negedge clk_sys);
			check_val(core_reset, st_model[st_reset] | st_model[st_trig_reset] | o_btn,
				"core_reset");
			if (o_we)
				st_model = o_data;
			check_val(dut.rotate, st_model[st_rotate], "rotate field");
			check_val(dut.scan_mode, st_model[st_scan_lo +: 2], "scanline field");
		end
	endtask

	task automatic sweep_video(input int mode);
		logic [col_w-1:0] o_r, o_g, o_b;
		logic o_hs, o_vs, o_blank;
		logic [31:0] r;
		// hold vsync so parity restarts even
		@(posedge clk_sys);
		core_vs     <= 1'b1;
		core_hs     <= 1'b0;
		core_hblank <= 1'b1;
		repeat (3) @(posedge clk_sys);
		write_status(32'(mode) << st_scan_lo);
		m_odd     = 1'b0;
		m_hs_prev = 1'b0;
		for (int i = 0; i < n_video; i++) begin
			o_r = core_r;
			o_g = core_g;
			o_b = core_b;
			o_hs = core_hs;
			o_vs = core_vs;
			o_blank = core_hblank | core_vblank;
			@(posedge clk_sys);
			r = next_random();
			core_r      <= r[3:0];
			core_g      <= r[7:4];
			core_b      <= r[11:8];
			core_hs     <= (r[14:12] == 3'd0);
			core_vs     <= (r[20:16] == 5'd0);
			core_hblank <= (r[22:21] == 2'd0);
			core_vblank <= (r[26:23] == 4'd0);
			@(negedge clk_sys);
			check_val(vid_r, o_blank ? 0 : (m_odd ? dim_expect(o_r, mode) : o_r), "vid_r");
			check_val(vid_g, o_blank ? 0 : (m_odd ? dim_expect(o_g, mode) : o_g), "vid_g");
			check_val(vid_b, o_blank ? 0 : (m_odd ? dim_expect(o_b, mode) : o_b), "vid_b");
			check_val(vid_hs, !o_hs, "vid_hs");
			check_val(vid_vs, !o_vs, "vid_vs");
			if (o_vs)
				m_odd = 1'b0;
			else if (o_hs && !m_hs_prev)
				m_odd = ~m_odd;
			m_hs_prev = o_hs;
		end
	endtask

	task automatic hold_audio();
		logic [dac_w-1:0] v;
		int ones;
		for (int k = 0; k < n_audio; k++) begin
			v = dac_w'(next_random());
			@(posedge clk_sys);
			core_audio <= v;
			@(posedge clk_sys); // first edge that uses v
			repeat (2) begin
				ones = 0;
				repeat (64) begin
					@(negedge clk_sys);
					ones += int'(audio_l);
					check_val(audio_r, audio_l, "audio_r mirror");
				end
				check_val(ones, v, "ones per 64-cycle window");
			end
		end
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		known_codes = '{kc_up, kc_down, kc_left, kc_right, kc_esc, kc_f1, kc_f2,
			kc_lshift, kc_ctrl, kc_alt, kc_space};
		{m_up, m_down, m_left, m_right, m_coin} = '0;
		{m_start1, m_start2, m_fire1, m_fire2, m_fire3} = '0;
		m_odd = 1'b0;
		m_hs_prev = 1'b0;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joy0 = '0;
		joy1 = '0;
		status_we = 1'b0;
		status_data = '0;
		host_reset_btn = 1'b0;
		core_r = '0;
		core_g = '0;
		core_b = '0;
		core_hs = 1'b0;
		core_vs = 1'b0;
		core_hblank = 1'b0;
		core_vblank = 1'b0;
		core_audio = '0;
		repeat (5) @(posedge clk_sys); // past reset
		count_strobes();
		press_keys(1'b0);
		press_keys(1'b1);
		poke_status();
		for (int m = 0; m < 4; m++)
			sweep_video(m);
		hold_audio();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("timeout: tests did not complete in %0d cycles", watchdog_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* flist.f */
hw/arcade_cfg_pkg.sv
hw/arcade_input_pkg.sv
hw/clock_enables.sv
hw/key_decoder.sv
hw/control_mapper.sv
hw/config_regs.sv
hw/video_blanker.sv
hw/sigma_delta_dac.sv
hw/arcade_io_top.sv
tb/tb_clock_gen.sv
tb/arcade_io_properties.sv
tb/arcade_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := arcade_io_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
